// File: src/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;     // data, address or instruction
    typedef logic [4:0]  reg_addr_t; // register index
    typedef logic [7:0]  byte_t;     // one uart byte
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  imm_sel_t;
    typedef logic [1:0]  wb_sel_t;

    // alu operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_PASS_B = 4'd6; // lui

    // immediate formats
    localparam imm_sel_t IMM_I = 3'd0;
    localparam imm_sel_t IMM_S = 3'd1;
    localparam imm_sel_t IMM_B = 3'd2;
    localparam imm_sel_t IMM_U = 3'd3;
    localparam imm_sel_t IMM_J = 3'd4;

    // write-back sources
    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    // rv32i major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_e;

    typedef enum logic [1:0] {COUNT, BYTES, DONE} load_state_e;

endpackage

// File: src/ctrl_if.sv
interface ctrl_if import rv_pkg::*; ();

    word_t   instr;       // from the fetch path
    logic    reg_write;
    logic    alu_src_pc;  // operand a is the pc
    logic    alu_src_imm; // operand b is the immediate
    alu_op_t alu_op;
    wb_sel_t wb_sel;
    logic    mem_write;
    logic    branch;
    logic    branch_ne;   // bne instead of beq
    logic    jump;
    logic    jalr;
    word_t   imm;

    modport decoder (
        input  instr,
        output reg_write, alu_src_pc, alu_src_imm, alu_op, wb_sel,
        output mem_write, branch, branch_ne, jump, jalr, imm
    );

    modport exec (
        output instr,
        input  reg_write, alu_src_pc, alu_src_imm, alu_op, wb_sel,
        input  mem_write, branch, branch_ne, jump, jalr, imm
    );

endinterface

// File: src/uart_receiver.sv
module uart_receiver import rv_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  rx_i,
    output byte_t byte_o,
    output logic  rx_done_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);

    rx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;   // position inside the bit period
    logic [2:0]       bit_idx;
    byte_t            shift_q;
    logic             rx_meta;
    logic             rx_sync;

    // two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            rx_done_o <= 1'b0;
        end else begin
            rx_done_o <= 1'b0;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= START; // falling start edge
                end
                START: begin
                    if (clk_cnt == HALF_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? IDLE : DATA; // glitch goes back to idle
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (clk_cnt == LAST_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (clk_cnt == LAST_CNT) begin
                        rx_done_o <= rx_sync; // low stop bit drops the byte
                        state     <= IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // lsb first, sampled mid-bit
    always_ff @(posedge clk) begin
        if (state == DATA && clk_cnt == LAST_CNT) shift_q <= {rx_sync, shift_q[7:1]};
    end

    assign byte_o = shift_q;

    a_single_done: assert property (@(posedge clk) disable iff (reset_i)
        rx_done_o |=> !rx_done_o);

endmodule

// File: src/program_loader.sv
module program_loader import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  byte_t                         byte_i,
    input  logic                          rx_done_i,
    output logic                          wr_en_o,
    output logic [$clog2(IMEM_DEPTH)-1:0] wr_addr_o,
    output word_t                         wr_data_o,
    output logic                          prog_rdy_o
);

    localparam int AW = $clog2(IMEM_DEPTH);

    load_state_e   state;
    logic [AW:0]   n_words;   // words still to load, clipped
    logic [AW:0]   n_clip;
    logic [AW-1:0] word_idx;
    logic [1:0]    lane;      // byte position inside the word
    logic [23:0]   low_bytes;
    logic          last_word;

    always_comb begin
        if (byte_i == '0) begin
            n_clip = (AW+1)'(1);          // zero count loads one word
        end else if (32'(byte_i) > IMEM_DEPTH) begin
            n_clip = (AW+1)'(IMEM_DEPTH);
        end else begin
            n_clip = (AW+1)'(byte_i);
        end
    end

    assign last_word = ({1'b0, word_idx} == n_words - 1'b1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= COUNT;
            n_words    <= '0;
            word_idx   <= '0;
            lane       <= '0;
            wr_en_o    <= 1'b0;
            prog_rdy_o <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;
            case (state)
                COUNT: begin
                    if (rx_done_i) begin
                        n_words  <= n_clip;
                        word_idx <= '0;
                        lane     <= '0;
                        state    <= BYTES;
                    end
                end
                BYTES: begin
                    if (rx_done_i) begin
                        lane <= lane + 2'd1;
                        if (lane == 2'd3) begin
                            wr_en_o  <= 1'b1;
                            word_idx <= word_idx + 1'b1;
                            if (last_word) state <= DONE;
                        end
                    end
                end
                DONE: prog_rdy_o <= 1'b1; // rises with the final write edge
                default: state <= COUNT;
            endcase
        end
    end

    // little-endian packing
    always_ff @(posedge clk) begin
        if (rx_done_i && state == BYTES) begin
            if (lane == 2'd3) begin
                wr_data_o <= {byte_i, low_bytes};
                wr_addr_o <= word_idx;
            end else begin
                low_bytes[lane*8 +: 8] <= byte_i;
            end
        end
    end

    a_no_write_after_ready: assert property (@(posedge clk) disable iff (reset_i)
        prog_rdy_o |-> !wr_en_o);

endmodule

// File: src/instruction_memory.sv
module instruction_memory import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          wr_en_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] wr_addr_i,
    input  word_t                         wr_data_i,
    input  word_t                         rd_addr_i, // byte address
    output word_t                         rd_data_o
);

    localparam int AW = $clog2(IMEM_DEPTH);

    word_t mem [IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) mem[wr_addr_i] <= wr_data_i;
    end

    // upper address bits dropped so fetch wraps
    assign rd_data_o = mem[rd_addr_i[AW+1:2]];

endmodule

// File: src/control_unit.sv
module control_unit import rv_pkg::*; (
    ctrl_if.decoder ctl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5; // sub select
    imm_sel_t   imm_sel;
    word_t      ins;

    assign ins      = ctl.instr;
    assign opcode   = ins[6:0];
    assign funct3   = ins[14:12];
    assign funct7_5 = ins[30];

    always_comb begin
        ctl.reg_write   = 1'b0;
        ctl.alu_src_pc  = 1'b0;
        ctl.alu_src_imm = 1'b0;
        ctl.alu_op      = ALU_ADD;
        ctl.wb_sel      = WB_ALU;
        ctl.mem_write   = 1'b0;
        ctl.branch      = 1'b0;
        ctl.branch_ne   = 1'b0;
        ctl.jump        = 1'b0;
        ctl.jalr        = 1'b0;
        imm_sel         = IMM_I;
        case (opcode)
            OP_R: begin
                ctl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctl.alu_op = funct7_5 ? ALU_SUB : ALU_ADD;
                    3'b111:  ctl.alu_op = ALU_AND;
                    3'b110:  ctl.alu_op = ALU_OR;
                    3'b100:  ctl.alu_op = ALU_XOR;
                    3'b010:  ctl.alu_op = ALU_SLT;
                    default: ctl.reg_write = 1'b0; // shifts etc not supported
                endcase
            end
            OP_I: begin
                ctl.reg_write   = 1'b1;
                ctl.alu_src_imm = 1'b1;
                case (funct3)
                    3'b000:  ctl.alu_op = ALU_ADD;
                    3'b111:  ctl.alu_op = ALU_AND;
                    3'b110:  ctl.alu_op = ALU_OR;
                    3'b100:  ctl.alu_op = ALU_XOR;
                    default: ctl.reg_write = 1'b0;
                endcase
            end
            OP_LUI: begin
                ctl.reg_write   = 1'b1;
                ctl.alu_src_imm = 1'b1;
                ctl.alu_op      = ALU_PASS_B;
                imm_sel         = IMM_U;
            end
            OP_LOAD: begin
                ctl.reg_write   = 1'b1;
                ctl.alu_src_imm = 1'b1;
                ctl.wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                ctl.mem_write   = 1'b1;
                ctl.alu_src_imm = 1'b1;
                imm_sel         = IMM_S;
            end
            OP_BRANCH: begin
                // alu forms the target, compare lives in the datapath
                ctl.alu_src_pc  = 1'b1;
                ctl.alu_src_imm = 1'b1;
                ctl.branch      = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctl.branch_ne   = (funct3 == 3'b001);
                imm_sel         = IMM_B;
            end
            OP_JAL: begin
                ctl.reg_write   = 1'b1;
                ctl.alu_src_pc  = 1'b1;
                ctl.alu_src_imm = 1'b1;
                ctl.wb_sel      = WB_PC4;
                ctl.jump        = 1'b1;
                imm_sel         = IMM_J;
            end
            OP_JALR: begin
                ctl.reg_write   = 1'b1;
                ctl.alu_src_imm = 1'b1;
                ctl.wb_sel      = WB_PC4;
                ctl.jump        = 1'b1;
                ctl.jalr        = 1'b1;
            end
            default: ; // unknown opcode acts as a nop
        endcase
    end

    always_comb begin
        case (imm_sel)
            IMM_I:   ctl.imm = {{20{ins[31]}}, ins[31:20]};
            IMM_S:   ctl.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            IMM_B:   ctl.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            IMM_U:   ctl.imm = {ins[31:12], 12'b0};
            IMM_J:   ctl.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: ctl.imm = '0;
        endcase
    end

endmodule

// File: src/register_file.sv
module register_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      we_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  word_t     wd_i,
    output word_t     rd1_o,
    output word_t     rd2_o,
    output word_t     x10_o
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin // x0 stays zero
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = regs[rs1_i];
    assign rd2_o = regs[rs2_i];
    assign x10_o = regs[10];  // a0, shown at the top

    a_x0_zero: assert property (@(posedge clk) disable iff (reset_i)
        (rs1_i == '0) |-> (rd1_o == '0));

endmodule

// File: src/datapath.sv
module datapath import rv_pkg::*; #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        run_i,    // program loaded
    ctrl_if.exec        ctl,
    output word_t       pc_o,
    input  word_t       instr_i,
    output word_t       result_o
);

    localparam int DAW = $clog2(DMEM_DEPTH);

    word_t pc_q;
    word_t pc_plus4;
    word_t next_pc;
    word_t rs1_val;
    word_t rs2_val;
    word_t op_a;
    word_t op_b;
    word_t alu_res;
    word_t mem_rd;
    word_t wb_data;
    logic  take_branch;

    word_t dmem [DMEM_DEPTH];

    assign ctl.instr = instr_i;

    register_file u_regs (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (ctl.reg_write & run_i),
        .rs1_i   (instr_i[19:15]),
        .rs2_i   (instr_i[24:20]),
        .rd_i    (instr_i[11:7]),
        .wd_i    (wb_data),
        .rd1_o   (rs1_val),
        .rd2_o   (rs2_val),
        .x10_o   (result_o)
    );

    assign op_a = ctl.alu_src_pc  ? pc_q    : rs1_val;
    assign op_b = ctl.alu_src_imm ? ctl.imm : rs2_val;

    always_comb begin
        case (ctl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // beq or bne depending on branch_ne
    assign take_branch = ctl.branch & ((rs1_val == rs2_val) ^ ctl.branch_ne);
    assign pc_plus4    = pc_q + 32'd4;

    always_comb begin
        if (ctl.jalr) begin
            next_pc = {alu_res[31:1], 1'b0};
        end else if (ctl.jump || take_branch) begin
            next_pc = alu_res; // pc + imm
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (run_i) begin
            pc_q <= next_pc;   // held at 0 while loading
        end
    end

    // word-only data memory, wraps on depth
    always_ff @(posedge clk) begin
        if (run_i && ctl.mem_write) dmem[alu_res[DAW+1:2]] <= rs2_val;
    end

    assign mem_rd = dmem[alu_res[DAW+1:2]];

    always_comb begin
        case (ctl.wb_sel)
            WB_MEM:  wb_data = mem_rd;
            WB_PC4:  wb_data = pc_plus4; // link address
            default: wb_data = alu_res;
        endcase
    end

    assign pc_o = pc_q;

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00);

endmodule

// File: src/microprocessor_top.sv
module microprocessor_top import rv_pkg::*; #(
    parameter int CLKS_PER_BIT = 434,
    parameter int IMEM_DEPTH   = 64,
    parameter int DMEM_DEPTH   = 64
) (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  rx_i,
    output logic  prog_rdy_o,
    output word_t pc_o,
    output word_t result_o
);

    byte_t                         uart_byte;
    logic                          rx_done;
    logic                          imem_wr_en;
    logic [$clog2(IMEM_DEPTH)-1:0] imem_wr_addr;
    word_t                         imem_wr_data;
    word_t                         instr;

    ctrl_if ctl_bus ();

    uart_receiver #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk       (clk),
        .reset_i   (reset_i),
        .rx_i      (rx_i),
        .byte_o    (uart_byte),
        .rx_done_o (rx_done)
    );

    program_loader #(.IMEM_DEPTH(IMEM_DEPTH)) u_loader (
        .clk        (clk),
        .reset_i    (reset_i),
        .byte_i     (uart_byte),
        .rx_done_i  (rx_done),
        .wr_en_o    (imem_wr_en),
        .wr_addr_o  (imem_wr_addr),
        .wr_data_o  (imem_wr_data),
        .prog_rdy_o (prog_rdy_o)
    );

    instruction_memory #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
        .clk       (clk),
        .wr_en_i   (imem_wr_en),
        .wr_addr_i (imem_wr_addr),
        .wr_data_i (imem_wr_data),
        .rd_addr_i (pc_o),
        .rd_data_o (instr)
    );

    control_unit u_ctrl (
        .ctl (ctl_bus.decoder)
    );

    datapath #(.DMEM_DEPTH(DMEM_DEPTH)) u_dp (
        .clk      (clk),
        .reset_i  (reset_i),
        .run_i    (prog_rdy_o),
        .ctl      (ctl_bus.exec),
        .pc_o     (pc_o),
        .instr_i  (instr),
        .result_o (result_o)
    );

endmodule

// File: verif/tb_checker.sv
module tb_checker import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  prog_rdy_i,
    input  word_t pc_i,
    input  word_t result_i,
    input  word_t prog_i [IMEM_DEPTH],
    input  int    n_words_i,     // count byte of the program being loaded
    input  int    n_steps_i,     // retired instructions to follow
    input  int    bytes_sent_i,
    output logic  check_done_o,
    output int    load_errors_o,
    output int    pc_errors_o,
    output int    result_errors_o
);

    timeunit 1ns;
    timeprecision 100ps;

    word_t model_regs [32];
    word_t model_mem [DMEM_DEPTH];
    word_t model_pc;
    int    step;
    logic  running;

    // executes one instruction on the model state, returns the next pc
    function automatic word_t step_model(input word_t pc, input word_t ins);
        word_t rs1v;
        word_t rs2v;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        word_t res;
        word_t npc;
        logic  wr;
        rs1v  = model_regs[ins[19:15]];
        rs2v  = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        res   = '0;
        npc   = pc + 32'd4;
        wr    = 1'b0;
        case (ins[6:0])
            OP_R: begin
                wr = 1'b1;
                case (ins[14:12])
                    3'b000:  res = ins[30] ? rs1v - rs2v : rs1v + rs2v;
                    3'b010:  res = ($signed(rs1v) < $signed(rs2v)) ? 32'd1 : 32'd0;
                    3'b100:  res = rs1v ^ rs2v;
                    3'b110:  res = rs1v | rs2v;
                    3'b111:  res = rs1v & rs2v;
                    default: wr = 1'b0;
                endcase
            end
            OP_I: begin
                wr = 1'b1;
                case (ins[14:12])
                    3'b000:  res = rs1v + imm_i;
                    3'b100:  res = rs1v ^ imm_i;
                    3'b110:  res = rs1v | imm_i;
                    3'b111:  res = rs1v & imm_i;
                    default: wr = 1'b0;
                endcase
            end
            OP_LUI: begin
                wr  = 1'b1;
                res = {ins[31:12], 12'h000};
            end
            OP_LOAD: begin
                wr  = 1'b1;
                res = model_mem[((rs1v + imm_i) >> 2) % DMEM_DEPTH];
            end
            OP_STORE: model_mem[((rs1v + imm_s) >> 2) % DMEM_DEPTH] = rs2v;
            OP_BRANCH: begin
                if ((ins[14:12] == 3'b000 && rs1v == rs2v) ||
                    (ins[14:12] == 3'b001 && rs1v != rs2v)) begin
                    npc = pc + imm_b;
                end
            end
            OP_JAL: begin
                wr  = 1'b1;
                res = pc + 32'd4;
                npc = pc + imm_j;
            end
            OP_JALR: begin
                wr  = 1'b1;
                res = pc + 32'd4;
                npc = (rs1v + imm_i) & ~32'd1;
            end
            default: ; // anything else retires as a nop
        endcase
        if (wr && ins[11:7] != 5'd0) model_regs[ins[11:7]] = res;
        return npc;
    endfunction

    task automatic start_model();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        model_pc = '0;
        step     = 0;
    endtask

    task automatic compare_outputs();
        if (pc_i !== model_pc) begin
            $display("FAILED at %0t: pc_o expected %h, got %h", $time, model_pc, pc_i);
            pc_errors_o++;
        end
        if (result_i !== model_regs[10]) begin
            $display("FAILED at %0t: result_o expected %h, got %h",
                     $time, model_regs[10], result_i);
            result_errors_o++;
        end
    endtask

    // outputs are sampled on the falling edge, away from the dut updates
    initial begin
        check_done_o    = 1'b0;
        load_errors_o   = 0;
        pc_errors_o     = 0;
        result_errors_o = 0;
        running         = 1'b0;
        step            = 0;
        forever begin
            @(negedge clk);
            if (reset_i || !prog_rdy_i) begin
                running      = 1'b0;
                check_done_o = 1'b0;
                if (!reset_i && pc_i !== '0) begin // pc held while loading
                    $display("FAILED at %0t: pc_o expected %h, got %h", $time, 32'h0, pc_i);
                    load_errors_o++;
                end
            end else if (!check_done_o) begin
                if (!running) begin
                    running = 1'b1;
                    start_model();
                    if (bytes_sent_i != 4 * n_words_i + 1) begin
                        $display("FAILED at %0t: prog_rdy_o high after %0d bytes, expected %0d",
                                 $time, bytes_sent_i, 4 * n_words_i + 1);
                        load_errors_o++;
                    end
                end
                compare_outputs();
                model_pc = step_model(model_pc, prog_i[(model_pc >> 2) % IMEM_DEPTH]);
                step++;
                if (step > n_steps_i) check_done_o = 1'b1;
            end
        end
    end

endmodule

// File: verif/tb_top.sv
module tb_top import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_BIT = 8;
    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int N_RAND       = 24;
    localparam int TOTAL_WORDS  = 5 + 15 + 10 + 16 + N_RAND;
    localparam int TOTAL_BYTES  = 4 * TOTAL_WORDS + 5;     // count byte per program
    localparam int TOTAL_STEPS  = 8 + 20 + 14 + 16 + 30;
    localparam int TIMEOUT_NS   = 2 * CLK_PERIOD *
        (TOTAL_BYTES * 10 * CLKS_PER_BIT + TOTAL_STEPS + 5 * (RESET_CYCLES + 8));

    logic   clk;
    logic   reset_i;
    logic   rx_i;
    logic   prog_rdy;
    word_t  pc;
    word_t  result;
    word_t  prog [IMEM_DEPTH];
    int     prog_len;
    int     n_steps;
    int     bytes_sent;
    logic   check_done;
    int     load_errors;
    int     pc_errors;
    int     result_errors;
    integer seed;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    microprocessor_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .IMEM_DEPTH   (IMEM_DEPTH),
        .DMEM_DEPTH   (DMEM_DEPTH)
    ) UUT (
        .clk        (clk),
        .reset_i    (reset_i),
        .rx_i       (rx_i),
        .prog_rdy_o (prog_rdy),
        .pc_o       (pc),
        .result_o   (result)
    );

    tb_checker #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) u_checker (
        .clk             (clk),
        .reset_i         (reset_i),
        .prog_rdy_i      (prog_rdy),
        .pc_i            (pc),
        .result_i        (result),
        .prog_i          (prog),
        .n_words_i       (prog_len),
        .n_steps_i       (n_steps),
        .bytes_sent_i    (bytes_sent),
        .check_done_o    (check_done),
        .load_errors_o   (load_errors),
        .pc_errors_o     (pc_errors),
        .result_errors_o (result_errors)
    );

    function automatic word_t rtype(input int f7, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_R};
    endfunction

    // also used for loads and jalr
    function automatic word_t itype(input int imm, input int rs1, input int f3,
                                    input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t stype(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t btype(input int off, input int rs2, input int rs1, input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t utype(input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], OP_LUI};
    endfunction

    function automatic word_t jtype(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
    endfunction

    task automatic append_word(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;
    endtask

    // 8n1 frame, lsb first, entered 1 ns after a rising edge
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_i = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
        bytes_sent++;
    endtask

    task automatic run_program(input int steps);
        apply_reset();
        n_steps    = steps;
        bytes_sent = 0;
        send_byte(byte_t'(prog_len));
        for (int w = 0; w < prog_len; w++) begin
            for (int b = 0; b < 4; b++) begin
                send_byte(prog[w][8*b +: 8]);
            end
        end
        wait (check_done); // bounded by the watchdog
    endtask

    task automatic build_load_program();
        prog_len = 0;
        append_word(itype(5, 0, 0, 10, OP_I));
        append_word(itype(7, 0, 0, 11, OP_I));
        append_word(rtype(0, 11, 10, 0, 10));
        append_word(rtype(0, 11, 10, 4, 10));
        append_word(jtype(0, 0));              // self loop
    endtask

    task automatic build_arith_program();
        prog_len = 0;
        append_word(itype(-3, 0, 0, 1, OP_I));
        append_word(itype(9, 0, 0, 2, OP_I));
        append_word(rtype(0, 2, 1, 0, 10));    // add
        append_word(rtype(32, 2, 1, 0, 10));   // sub
        append_word(rtype(0, 2, 1, 7, 10));
        append_word(rtype(0, 2, 1, 6, 10));
        append_word(rtype(0, 2, 1, 4, 10));
        append_word(rtype(0, 2, 1, 2, 10));    // slt -3 < 9
        append_word(rtype(0, 1, 2, 2, 10));    // slt 9 < -3
        append_word(itype(240, 1, 7, 10, OP_I));
        append_word(itype(-256, 2, 6, 10, OP_I));
        append_word(itype(1365, 1, 4, 10, OP_I));
        append_word(utype(32'hABCDE, 10));
        append_word(itype(-1, 10, 0, 10, OP_I));
        append_word(jtype(0, 0));
    endtask

    task automatic build_memory_program();
        prog_len = 0;
        append_word(utype(32'h12345, 5));
        append_word(itype(32'h678, 5, 0, 5, OP_I));
        append_word(itype(16, 0, 0, 6, OP_I));
        append_word(itype(8, 0, 0, 7, OP_I));
        append_word(stype(4, 5, 6));               // byte address 20
        append_word(itype(12, 7, 2, 10, OP_LOAD)); // same word through x7
        append_word(stype(-4, 10, 6));             // byte address 12
        append_word(itype(0, 0, 0, 10, OP_I));
        append_word(itype(4, 7, 2, 10, OP_LOAD));
        append_word(jtype(0, 0));
    endtask

    task automatic build_flow_program();
        prog_len = 0;
        append_word(itype(3, 0, 0, 1, OP_I));
        append_word(itype(3, 0, 0, 2, OP_I));
        append_word(btype(8, 2, 1, 0));        // beq taken
        append_word(itype(99, 0, 0, 10, OP_I));
        append_word(btype(8, 2, 1, 1));        // bne not taken
        append_word(itype(1, 0, 0, 10, OP_I));
        append_word(btype(8, 0, 10, 0));
        append_word(btype(8, 0, 10, 1));
        append_word(itype(77, 0, 0, 10, OP_I));
        append_word(jtype(12, 10));            // link 40, on to 48
        append_word(itype(-1, 0, 0, 10, OP_I));
        append_word(itype(-2, 0, 0, 10, OP_I));
        append_word(itype(61, 0, 0, 3, OP_I));
        append_word(itype(0, 3, 0, 10, OP_JALR)); // odd target, lands on 60
        append_word(itype(55, 0, 0, 10, OP_I));
        append_word(jtype(0, 0));
    endtask

    task automatic build_random_program();
        integer r;
        int     rd;
        int     rs1;
        int     rs2;
        int     imm;
        prog_len = 0;
        append_word(itype(-1, 0, 0, 0, OP_I));  // write into x0
        append_word(itype(5, 0, 0, 10, OP_I));  // x0 read back through x10
        for (int i = 0; i < N_RAND - 3; i++) begin
            r   = $random(seed);
            rd  = r[12] ? 10 : int'(r[3:0]); // x0 shows up as a target too
            rs1 = r[7:4];
            rs2 = r[11:8];
            imm = r[27:16];
            case (r[31:30])
                2'd0:    append_word(itype(imm, rs1, 0, rd, OP_I));
                2'd1:    append_word(rtype(0, rs2, rs1, 0, rd));
                2'd2:    append_word(rtype(0, rs2, rs1, 4, rd));
                default: append_word(rtype(32, rs2, rs1, 0, rd));
            endcase
        end
        append_word(jtype(0, 0));
    endtask

    initial begin
        reset_i    = 1'b1;
        rx_i       = 1'b1;
        prog_len   = 0;
        n_steps    = 0;
        bytes_sent = 0;
        seed       = 8505;
        build_load_program();
        run_program(8);
        build_arith_program();
        run_program(20);
        build_memory_program();
        run_program(14);
        build_flow_program();
        run_program(16);
        build_random_program();
        run_program(30);
        $display("error counts: load %0d, pc %0d, result %0d",
                 load_errors, pc_errors, result_errors);
        if (load_errors + pc_errors + result_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, a program never finished loading or running",
                 TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: files.f
src/rv_pkg.sv
src/ctrl_if.sv
src/uart_receiver.sv
src/program_loader.sv
src/instruction_memory.sv
src/control_unit.sv
src/register_file.sv
src/datapath.sv
src/microprocessor_top.sv
verif/tb_checker.sv
verif/tb_top.sv
